// ==== source/cu_config.svh ====
`ifndef CU_CONFIG_SVH
`define CU_CONFIG_SVH

// Instruction byte layout: opcode | ra/func | rb
`define CU_OPCODE_W 4   // Major opcode, upper nibble
`define CU_REG_W 2      // Register number or function select

// Control word field widths
`define CU_ALU_OP_W 4   // ALU operation code
`define CU_PC_SRC_W 3   // Fetch unit PC mux select
`define CU_WB_SEL_W 3   // Write-back mux select

`endif

// ==== source/isa_pkg.sv ====
`include "cu_config.svh"

package isa_pkg;

    // Major opcodes, instruction[7:4]
    typedef enum logic [`CU_OPCODE_W-1:0] {
        OP_NOP         = 4'd0,
        OP_MOV         = 4'd1,
        OP_ADD         = 4'd2,
        OP_SUB         = 4'd3,
        OP_AND         = 4'd4,
        OP_OR          = 4'd5,
        OP_ROT_CARRY   = 4'd6,   // RLC, RRC, SETC, CLRC
        OP_STACK_IO    = 4'd7,   // PUSH, POP, OUT, IN
        OP_UNARY       = 4'd8,   // NOT, NEG, INC, DEC
        OP_COND_BRANCH = 4'd9,   // JZ, JN, JC, JV
        OP_LOOP        = 4'd10,
        OP_JUMP        = 4'd11,  // JMP, CALL, RET, RTI
        OP_LOAD_STORE  = 4'd12,  // LDM, LDD, STD
        OP_LDI         = 4'd13,
        OP_STI         = 4'd14   // Code 15 spare
    } opcode_e;

    // Function selects in the middle field
    localparam logic [`CU_REG_W-1:0] FN_RLC  = 2'd0;
    localparam logic [`CU_REG_W-1:0] FN_RRC  = 2'd1;
    localparam logic [`CU_REG_W-1:0] FN_SETC = 2'd2;
    localparam logic [`CU_REG_W-1:0] FN_CLRC = 2'd3;
    localparam logic [`CU_REG_W-1:0] FN_PUSH = 2'd0;
    localparam logic [`CU_REG_W-1:0] FN_POP  = 2'd1;
    localparam logic [`CU_REG_W-1:0] FN_OUT  = 2'd2;
    localparam logic [`CU_REG_W-1:0] FN_IN   = 2'd3;
    localparam logic [`CU_REG_W-1:0] FN_JZ   = 2'd0;
    localparam logic [`CU_REG_W-1:0] FN_JN   = 2'd1;
    localparam logic [`CU_REG_W-1:0] FN_JC   = 2'd2;
    localparam logic [`CU_REG_W-1:0] FN_JV   = 2'd3;
    localparam logic [`CU_REG_W-1:0] FN_JMP  = 2'd0;
    localparam logic [`CU_REG_W-1:0] FN_CALL = 2'd1;
    localparam logic [`CU_REG_W-1:0] FN_RET  = 2'd2;
    localparam logic [`CU_REG_W-1:0] FN_RTI  = 2'd3;
    localparam logic [`CU_REG_W-1:0] FN_LDM  = 2'd0;
    localparam logic [`CU_REG_W-1:0] FN_LDD  = 2'd1;
    localparam logic [`CU_REG_W-1:0] FN_STD  = 2'd2;

    // ALU operation codes, RRC on its own code
    typedef enum logic [`CU_ALU_OP_W-1:0] {
        ALU_NONE   = 4'd0,
        ALU_PASS_B = 4'd1,   // MOV
        ALU_ADD    = 4'd2,
        ALU_SUB    = 4'd3,
        ALU_AND    = 4'd4,
        ALU_OR     = 4'd5,
        ALU_RLC    = 4'd6,
        ALU_RRC    = 4'd7,
        ALU_UNARY  = 4'd8    // Sub-op picked by ALU from func
    } alu_op_e;

    typedef struct packed {
        opcode_e                opcode;
        logic [`CU_REG_W-1:0]   ra;
        logic [`CU_REG_W-1:0]   rb;
    } a_fmt_t;

    typedef struct packed {
        opcode_e                opcode;
        logic [`CU_REG_W-1:0]   func;   // Sub-operation select
        logic [`CU_REG_W-1:0]   rb;
    } b_fmt_t;

    // Same byte, middle field as register or as function
    typedef union packed {
        a_fmt_t a;
        b_fmt_t b;
    } instr_u;

endpackage

// ==== source/ctrl_pkg.sv ====
`include "cu_config.svh"

package ctrl_pkg;

    typedef enum logic [`CU_PC_SRC_W-1:0] {
        PC_INC   = 3'd0,
        PC_INC2  = 3'd1,
        PC_REG   = 3'd2,   // Branch target from rb
        PC_STACK = 3'd3,   // Return address
        PC_VEC0  = 3'd4,   // Reset vector M[0]
        PC_VEC1  = 3'd5    // Interrupt vector M[1]
    } pc_src_e;

    typedef enum logic [1:0] {
        MEM_PC  = 2'd0,
        MEM_RA  = 2'd1,
        MEM_SP  = 2'd2,
        MEM_IMM = 2'd3
    } mem_src_e;

    typedef enum logic [`CU_WB_SEL_W-1:0] {
        WB_MEM     = 3'd0,
        WB_PC      = 3'd1,
        WB_IMM     = 3'd2,
        WB_ALU     = 3'd3,
        WB_IN_PORT = 3'd4
    } wb_sel_e;

    typedef enum logic [1:0] {
        PUSH_RB      = 2'd0,
        PUSH_PC_NEXT = 2'd1,
        PUSH_PC      = 2'd2
    } push_sel_e;

    typedef enum logic {
        POP_RB = 1'b0,
        POP_PC = 1'b1
    } pop_sel_e;

    typedef struct packed {
        logic z;
        logic n;
        logic c;
        logic v;
    } flags_t;

    typedef struct packed {
        isa_pkg::alu_op_e alu_op;
        logic             dec_ra;   // LOOP counter decrement
    } alu_ctrl_t;

    typedef struct packed {
        logic                 reg_write;
        logic [`CU_REG_W-1:0] reg_dst;
        wb_sel_e              wb_sel;
    } reg_ctrl_t;

    typedef struct packed {
        logic      mem_read;
        logic      mem_write;
        mem_src_e  mem_src;
        logic      stack_push;
        logic      stack_pop;
        push_sel_e push_sel;
        pop_sel_e  pop_sel;
    } mem_ctrl_t;

    typedef struct packed {
        logic    pc_write;
        pc_src_e pc_src;
        logic    ir_write;
        logic    imm_write;
        logic    flush;     // Kill fetched instruction
    } pc_ctrl_t;

    typedef struct packed {
        logic setc;
        logic clrc;
        logic save_flags;
        logic restore_flags;
        logic interrupt_save;
    } flag_ctrl_t;

    typedef struct packed {
        logic port_out_write;
        logic port_in_read;
    } io_ctrl_t;

    // 34 bits, ALU group in the top bits
    typedef struct packed {
        alu_ctrl_t  alu;
        reg_ctrl_t  regs;
        mem_ctrl_t  mem;
        pc_ctrl_t   pc;
        flag_ctrl_t flag;
        io_ctrl_t   io;
    } ctrl_word_t;

    typedef enum logic [1:0] {
        IDLE        = 2'd0,   // Normal decode
        FETCH2      = 2'd1,   // Second byte of LDM/LDD/STD
        INT_HANDLE  = 2'd2,
        LOOP_DECIDE = 2'd3
    } seq_state_e;

endpackage

// ==== source/instr_decoder.sv ====
`timescale 1ns/1ps
`include "cu_config.svh"

module instr_decoder (
    input  isa_pkg::instr_u     instruction,
    input  ctrl_pkg::flags_t    flags,
    output ctrl_pkg::ctrl_word_t decoded,
    output logic                two_byte_req,
    output logic                loop_req
);

    isa_pkg::opcode_e       opcode;
    logic [`CU_REG_W-1:0]   ra;
    logic [`CU_REG_W-1:0]   rb;
    logic [`CU_REG_W-1:0]   func;
    logic                   taken;

    assign opcode = instruction.a.opcode;
    assign ra     = instruction.a.ra;     // A-format view
    assign rb     = instruction.a.rb;
    assign func   = instruction.b.func;   // B-format view of same bits

    // Branch condition picked by func
    always_comb begin
        case (func)
            isa_pkg::FN_JZ: taken = flags.z;
            isa_pkg::FN_JN: taken = flags.n;
            isa_pkg::FN_JC: taken = flags.c;
            default:        taken = flags.v;   // JV
        endcase
    end

    always_comb begin
        decoded      = '0;
        two_byte_req = 1'b0;
        loop_req     = 1'b0;
        decoded.mem.mem_read = 1'b1;              // Fetch next byte
        decoded.pc.pc_write  = 1'b1;
        decoded.pc.pc_src    = ctrl_pkg::PC_INC;
        decoded.pc.ir_write  = 1'b1;
        case (opcode)
            isa_pkg::OP_MOV, isa_pkg::OP_ADD, isa_pkg::OP_SUB,
            isa_pkg::OP_AND, isa_pkg::OP_OR: begin
                decoded.regs.reg_write = 1'b1;
                decoded.regs.reg_dst   = ra;      // ra op rb into ra
                decoded.regs.wb_sel    = ctrl_pkg::WB_ALU;
                case (opcode)
                    isa_pkg::OP_MOV: decoded.alu.alu_op = isa_pkg::ALU_PASS_B;
                    isa_pkg::OP_ADD: decoded.alu.alu_op = isa_pkg::ALU_ADD;
                    isa_pkg::OP_SUB: decoded.alu.alu_op = isa_pkg::ALU_SUB;
                    isa_pkg::OP_AND: decoded.alu.alu_op = isa_pkg::ALU_AND;
                    default:         decoded.alu.alu_op = isa_pkg::ALU_OR;
                endcase
            end
            isa_pkg::OP_ROT_CARRY: begin
                case (func)
                    isa_pkg::FN_RLC, isa_pkg::FN_RRC: begin
                        decoded.alu.alu_op = (func == isa_pkg::FN_RLC) ?
                                             isa_pkg::ALU_RLC : isa_pkg::ALU_RRC;
                        decoded.regs.reg_write = 1'b1;
                        decoded.regs.reg_dst   = rb;  // Rotate in place
                        decoded.regs.wb_sel    = ctrl_pkg::WB_ALU;
                    end
                    isa_pkg::FN_SETC: decoded.flag.setc = 1'b1;
                    default:          decoded.flag.clrc = 1'b1;   // CLRC
                endcase
            end
            isa_pkg::OP_STACK_IO: begin
                case (func)
                    isa_pkg::FN_PUSH: begin
                        decoded.mem.stack_push = 1'b1;
                        decoded.mem.mem_write  = 1'b1;
                        decoded.mem.mem_src    = ctrl_pkg::MEM_SP;
                        decoded.mem.push_sel   = ctrl_pkg::PUSH_RB;
                    end
                    isa_pkg::FN_POP: begin
                        decoded.mem.stack_pop  = 1'b1;
                        decoded.mem.mem_src    = ctrl_pkg::MEM_SP;
                        decoded.mem.pop_sel    = ctrl_pkg::POP_RB;
                        decoded.regs.reg_write = 1'b1;
                        decoded.regs.reg_dst   = rb;
                        decoded.regs.wb_sel    = ctrl_pkg::WB_MEM;
                    end
                    isa_pkg::FN_OUT: decoded.io.port_out_write = 1'b1;   // Port takes rb
                    default: begin                                      // IN
                        decoded.io.port_in_read = 1'b1;
                        decoded.regs.reg_write  = 1'b1;
                        decoded.regs.reg_dst    = rb;
                        decoded.regs.wb_sel     = ctrl_pkg::WB_IN_PORT;
                    end
                endcase
            end
            isa_pkg::OP_UNARY: begin
                decoded.alu.alu_op     = isa_pkg::ALU_UNARY;
                decoded.regs.reg_write = 1'b1;
                decoded.regs.reg_dst   = rb;
                decoded.regs.wb_sel    = ctrl_pkg::WB_ALU;
            end
            isa_pkg::OP_COND_BRANCH: begin
                if (taken) begin
                    decoded.pc.pc_src = ctrl_pkg::PC_REG;
                    decoded.pc.flush  = 1'b1;
                end
            end
            isa_pkg::OP_LOOP: begin
                decoded.alu.alu_op     = isa_pkg::ALU_UNARY;
                decoded.alu.dec_ra     = 1'b1;   // ra - 1
                decoded.regs.reg_write = 1'b1;
                decoded.regs.reg_dst   = ra;
                decoded.regs.wb_sel    = ctrl_pkg::WB_ALU;
                loop_req               = 1'b1;   // Branch decided next cycle
            end
            isa_pkg::OP_JUMP: begin
                decoded.pc.flush = 1'b1;         // All four redirect
                case (func)
                    isa_pkg::FN_JMP: decoded.pc.pc_src = ctrl_pkg::PC_REG;
                    isa_pkg::FN_CALL: begin
                        decoded.pc.pc_src      = ctrl_pkg::PC_REG;
                        decoded.mem.stack_push = 1'b1;
                        decoded.mem.mem_write  = 1'b1;
                        decoded.mem.mem_src    = ctrl_pkg::MEM_SP;
                        decoded.mem.push_sel   = ctrl_pkg::PUSH_PC_NEXT;   // Return addr
                    end
                    default: begin                                        // RET, RTI
                        decoded.pc.pc_src      = ctrl_pkg::PC_STACK;
                        decoded.mem.stack_pop  = 1'b1;
                        decoded.mem.mem_src    = ctrl_pkg::MEM_SP;
                        decoded.mem.pop_sel    = ctrl_pkg::POP_PC;
                        decoded.flag.restore_flags = (func == isa_pkg::FN_RTI);
                    end
                endcase
            end
            isa_pkg::OP_LOAD_STORE: begin
                if (func != 2'd3) begin          // Spare func acts as NOP
                    decoded.pc.ir_write  = 1'b0;
                    decoded.pc.imm_write = 1'b1; // Next byte is the immediate
                    two_byte_req         = 1'b1;
                end
                case (func)
                    isa_pkg::FN_LDM: begin
                        decoded.regs.reg_write = 1'b1;
                        decoded.regs.reg_dst   = rb;
                        decoded.regs.wb_sel    = ctrl_pkg::WB_IMM;
                    end
                    isa_pkg::FN_LDD: begin
                        decoded.mem.mem_src    = ctrl_pkg::MEM_IMM;
                        decoded.regs.reg_write = 1'b1;
                        decoded.regs.reg_dst   = rb;
                        decoded.regs.wb_sel    = ctrl_pkg::WB_MEM;
                    end
                    isa_pkg::FN_STD: begin
                        decoded.mem.mem_src   = ctrl_pkg::MEM_IMM;
                        decoded.mem.mem_write = 1'b1;
                    end
                    default: ;
                endcase
            end
            isa_pkg::OP_LDI: begin
                decoded.mem.mem_src    = ctrl_pkg::MEM_RA;   // Address in ra
                decoded.regs.reg_write = 1'b1;
                decoded.regs.reg_dst   = rb;
                decoded.regs.wb_sel    = ctrl_pkg::WB_MEM;
            end
            isa_pkg::OP_STI: begin
                decoded.mem.mem_src   = ctrl_pkg::MEM_RA;
                decoded.mem.mem_write = 1'b1;                // M[ra] <- rb
            end
            default: ;   // NOP and spare opcode 15
        endcase
    end

endmodule

// ==== source/ctrl_sequencer.sv ====
`timescale 1ns/1ps

module ctrl_sequencer (
    input  logic                 clk,
    input  logic                 rst,
    input  ctrl_pkg::ctrl_word_t decoded,
    input  logic                 two_byte_req,
    input  logic                 loop_req,
    input  logic                 interrupt,
    input  logic                 z_flag,
    output ctrl_pkg::ctrl_word_t ctrl
);

    ctrl_pkg::seq_state_e state;
    ctrl_pkg::seq_state_e state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ctrl_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Interrupt wins over two-byte and loop requests
    always_comb begin
        case (state)
            ctrl_pkg::IDLE: begin
                if (interrupt) begin
                    state_next = ctrl_pkg::INT_HANDLE;
                end else if (two_byte_req) begin
                    state_next = ctrl_pkg::FETCH2;
                end else if (loop_req) begin
                    state_next = ctrl_pkg::LOOP_DECIDE;
                end else begin
                    state_next = ctrl_pkg::IDLE;
                end
            end
            ctrl_pkg::FETCH2, ctrl_pkg::LOOP_DECIDE: begin
                state_next = interrupt ? ctrl_pkg::INT_HANDLE : ctrl_pkg::IDLE;
            end
            default: state_next = ctrl_pkg::IDLE;   // INT_HANDLE is one cycle
        endcase
    end

    always_comb begin
        ctrl = '0;
        if (!rst) begin
            case (state)
                ctrl_pkg::IDLE: ctrl = decoded;
                ctrl_pkg::FETCH2: begin
                    ctrl.mem.mem_read = 1'b1;              // Immediate byte at PC
                    ctrl.mem.mem_src  = ctrl_pkg::MEM_PC;
                    ctrl.pc.ir_write  = 1'b1;
                    ctrl.pc.pc_write  = 1'b1;
                    ctrl.pc.pc_src    = ctrl_pkg::PC_INC;
                end
                ctrl_pkg::LOOP_DECIDE: begin
                    ctrl.mem.mem_read = 1'b1;
                    ctrl.mem.mem_src  = ctrl_pkg::MEM_PC;
                    ctrl.pc.ir_write  = 1'b1;
                    ctrl.pc.pc_write  = 1'b1;
                    if (!z_flag) begin                     // Counter not yet zero
                        ctrl.pc.pc_src = ctrl_pkg::PC_REG;
                        ctrl.pc.flush  = 1'b1;
                    end else begin
                        ctrl.pc.pc_src = ctrl_pkg::PC_INC;   // Fall out of loop
                    end
                end
                default: begin                             // INT_HANDLE
                    ctrl.flag.interrupt_save = 1'b1;
                    ctrl.flag.save_flags     = 1'b1;
                    ctrl.mem.stack_push      = 1'b1;
                    ctrl.mem.push_sel        = ctrl_pkg::PUSH_PC_NEXT;
                    ctrl.mem.mem_write       = 1'b1;
                    ctrl.mem.mem_read        = 1'b1;       // Vector read at M[1]
                    ctrl.mem.mem_src         = ctrl_pkg::MEM_SP;
                    ctrl.pc.pc_write         = 1'b1;
                    ctrl.pc.pc_src           = ctrl_pkg::PC_VEC1;
                    ctrl.pc.flush            = 1'b1;       // Refetched after RTI
                end
            endcase
        end
    end

endmodule

// ==== source/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  isa_pkg::instr_u      instruction,
    input  ctrl_pkg::flags_t     flags,
    input  logic                 interrupt,
    output ctrl_pkg::ctrl_word_t ctrl
);

    ctrl_pkg::ctrl_word_t decoded;    // IDLE-state word
    logic                 two_byte_req;
    logic                 loop_req;

    instr_decoder u_decoder (
        .instruction  (instruction),
        .flags        (flags),
        .decoded      (decoded),
        .two_byte_req (two_byte_req),
        .loop_req     (loop_req)
    );

    // Overrides decoded word in extra cycles
    ctrl_sequencer u_sequencer (
        .clk          (clk),
        .rst          (rst),
        .decoded      (decoded),
        .two_byte_req (two_byte_req),
        .loop_req     (loop_req),
        .interrupt    (interrupt),
        .z_flag       (flags.z),
        .ctrl         (ctrl)
    );

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS  = 4,
    parameter int RST_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;   // 50% duty
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;                            // Released on an edge like other inputs
    end

endmodule

// ==== tests/tb_control_unit.sv ====
`timescale 1ns/1ps

module tb_control_unit;

    localparam int PERIOD_NS  = 4;
    localparam int RST_CYCLES = 8;
    localparam int N_ALU      = 40;     // Random A-format and unary bytes
    localparam int N_BRANCH   = 40;     // Random conditional branches
    localparam int N_TWO_BYTE = 3;      // LDM, LDD, STD
    localparam int N_LOOP     = 8;
    localparam int N_MISC     = 4;      // LDI, STI, spare codes, JMP, CALL
    localparam int TEST_CYCLES = RST_CYCLES + 1 + N_ALU + 8 + N_BRANCH + 3 * N_TWO_BYTE
                                 + 3 * N_LOOP + 6 * N_MISC + 14 + 2;

    logic                 clk;
    logic                 rst;
    isa_pkg::instr_u      instruction;
    ctrl_pkg::flags_t     flags;
    logic                 interrupt;
    ctrl_pkg::ctrl_word_t ctrl;

    ctrl_pkg::ctrl_word_t exp_word;      // Reference word for this cycle
    ctrl_pkg::seq_state_e st;            // Testbench copy of sequencer state
    string                test_name;     // Name of the stimulus now at the DUT
    string                phase;         // Name for the next applied stimulus
    logic [31:0]          seed;

    tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RST_CYCLES(RST_CYCLES)) u_clk (
        .clk (clk),
        .rst (rst)
    );

    control_unit i_dut (
        .clk         (clk),
        .rst         (rst),
        .instruction (instruction),
        .flags       (flags),
        .interrupt   (interrupt),
        .ctrl        (ctrl)
    );

    function automatic logic [7:0] rand8();
        seed = seed * 32'd1103515245 + 32'd12345;   // LCG step
        return seed[23:16];
    endfunction

    // Expected control word from the ISA rules and sequencer state
    function automatic ctrl_pkg::ctrl_word_t ref_word(input isa_pkg::instr_u ins,
            input ctrl_pkg::flags_t f, input ctrl_pkg::seq_state_e s);
        ctrl_pkg::ctrl_word_t w;
        logic [1:0] fn;
        logic       sel;
        w  = '0;
        fn = ins.b.func;
        w.mem.mem_read = 1'b1;
        w.pc.pc_write  = 1'b1;
        w.pc.pc_src    = ctrl_pkg::PC_INC;
        w.pc.ir_write  = 1'b1;
        if (s == ctrl_pkg::FETCH2) return w;
        if (s == ctrl_pkg::LOOP_DECIDE) begin
            if (!f.z) begin                  // Loop taken
                w.pc.pc_src = ctrl_pkg::PC_REG;
                w.pc.flush  = 1'b1;
            end
            return w;
        end
        if (s == ctrl_pkg::INT_HANDLE) begin
            w.pc.ir_write = 1'b0;
            w.flag.interrupt_save = 1'b1;
            w.flag.save_flags = 1'b1;
            w.mem.stack_push = 1'b1;
            w.mem.push_sel = ctrl_pkg::PUSH_PC_NEXT;
            w.mem.mem_write = 1'b1;
            w.mem.mem_src = ctrl_pkg::MEM_SP;
            w.pc.pc_src = ctrl_pkg::PC_VEC1;
            w.pc.flush = 1'b1;
            return w;
        end
        case (ins.a.opcode)
            isa_pkg::OP_MOV, isa_pkg::OP_ADD, isa_pkg::OP_SUB,
            isa_pkg::OP_AND, isa_pkg::OP_OR: begin
                w.regs.reg_write = 1'b1;
                w.regs.reg_dst = ins.a.ra;
                w.regs.wb_sel = ctrl_pkg::WB_ALU;
                case (ins.a.opcode)
                    isa_pkg::OP_MOV: w.alu.alu_op = isa_pkg::ALU_PASS_B;
                    isa_pkg::OP_ADD: w.alu.alu_op = isa_pkg::ALU_ADD;
                    isa_pkg::OP_SUB: w.alu.alu_op = isa_pkg::ALU_SUB;
                    isa_pkg::OP_AND: w.alu.alu_op = isa_pkg::ALU_AND;
                    default:         w.alu.alu_op = isa_pkg::ALU_OR;
                endcase
            end
            isa_pkg::OP_ROT_CARRY: begin
                if (fn == 2'd2) w.flag.setc = 1'b1;
                else if (fn == 2'd3) w.flag.clrc = 1'b1;
                else begin
                    w.alu.alu_op = (fn == 2'd0) ? isa_pkg::ALU_RLC : isa_pkg::ALU_RRC;
                    w.regs.reg_write = 1'b1;
                    w.regs.reg_dst = ins.a.rb;
                    w.regs.wb_sel = ctrl_pkg::WB_ALU;
                end
            end
            isa_pkg::OP_STACK_IO: begin
                if (fn == 2'd0) begin        // PUSH
                    w.mem.stack_push = 1'b1;
                    w.mem.mem_write = 1'b1;
                    w.mem.mem_src = ctrl_pkg::MEM_SP;
                end else if (fn == 2'd1) begin   // POP
                    w.mem.stack_pop = 1'b1;
                    w.mem.mem_src = ctrl_pkg::MEM_SP;
                    w.regs.reg_write = 1'b1;
                    w.regs.reg_dst = ins.a.rb;
                end else if (fn == 2'd2) begin
                    w.io.port_out_write = 1'b1;
                end else begin
                    w.io.port_in_read = 1'b1;
                    w.regs.reg_write = 1'b1;
                    w.regs.reg_dst = ins.a.rb;
                    w.regs.wb_sel = ctrl_pkg::WB_IN_PORT;
                end
            end
            isa_pkg::OP_UNARY, isa_pkg::OP_LOOP: begin
                w.alu.alu_op = isa_pkg::ALU_UNARY;
                w.alu.dec_ra = (ins.a.opcode == isa_pkg::OP_LOOP);
                w.regs.reg_write = 1'b1;
                w.regs.reg_dst = w.alu.dec_ra ? ins.a.ra : ins.a.rb;
                w.regs.wb_sel = ctrl_pkg::WB_ALU;
            end
            isa_pkg::OP_COND_BRANCH: begin
                sel = (fn == 2'd0) ? f.z : (fn == 2'd1) ? f.n : (fn == 2'd2) ? f.c : f.v;
                if (sel) begin
                    w.pc.pc_src = ctrl_pkg::PC_REG;
                    w.pc.flush = 1'b1;
                end
            end
            isa_pkg::OP_JUMP: begin
                w.pc.flush = 1'b1;
                if (fn[1]) begin             // RET or RTI
                    w.pc.pc_src = ctrl_pkg::PC_STACK;
                    w.mem.stack_pop = 1'b1;
                    w.mem.mem_src = ctrl_pkg::MEM_SP;
                    w.mem.pop_sel = ctrl_pkg::POP_PC;
                    w.flag.restore_flags = fn[0];
                end else begin
                    w.pc.pc_src = ctrl_pkg::PC_REG;
                    if (fn[0]) begin         // CALL
                        w.mem.stack_push = 1'b1;
                        w.mem.mem_write = 1'b1;
                        w.mem.mem_src = ctrl_pkg::MEM_SP;
                        w.mem.push_sel = ctrl_pkg::PUSH_PC_NEXT;
                    end
                end
            end
            isa_pkg::OP_LOAD_STORE: begin
                if (fn != 2'd3) begin
                    w.pc.ir_write = 1'b0;
                    w.pc.imm_write = 1'b1;
                end
                if (fn == 2'd1 || fn == 2'd2) w.mem.mem_src = ctrl_pkg::MEM_IMM;
                if (fn == 2'd2) w.mem.mem_write = 1'b1;
                if (fn == 2'd0 || fn == 2'd1) begin
                    w.regs.reg_write = 1'b1;
                    w.regs.reg_dst = ins.a.rb;
                    w.regs.wb_sel = (fn == 2'd0) ? ctrl_pkg::WB_IMM : ctrl_pkg::WB_MEM;
                end
            end
            isa_pkg::OP_LDI, isa_pkg::OP_STI: begin
                w.mem.mem_src = ctrl_pkg::MEM_RA;
                w.mem.mem_write = (ins.a.opcode == isa_pkg::OP_STI);
                w.regs.reg_write = !w.mem.mem_write;
                if (w.regs.reg_write) w.regs.reg_dst = ins.a.rb;   // LDI only
            end
            default: ;                       // NOP, spare 15
        endcase
        return w;
    endfunction

    function automatic ctrl_pkg::seq_state_e step_state(input ctrl_pkg::seq_state_e s,
            input isa_pkg::instr_u ins, input logic irq);
        if (irq && s != ctrl_pkg::INT_HANDLE) return ctrl_pkg::INT_HANDLE;
        if (s != ctrl_pkg::IDLE) return ctrl_pkg::IDLE;
        if (ins.b.opcode == isa_pkg::OP_LOAD_STORE && ins.b.func != 2'd3) return ctrl_pkg::FETCH2;
        if (ins.b.opcode == isa_pkg::OP_LOOP) return ctrl_pkg::LOOP_DECIDE;
        return ctrl_pkg::IDLE;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) st <= ctrl_pkg::IDLE;
        else st <= step_state(st, instruction, interrupt);
    end

    always_comb exp_word = ref_word(instruction, flags, st);

    task automatic report_mismatch(input ctrl_pkg::ctrl_word_t expected,
            input ctrl_pkg::ctrl_word_t actual);
        $display("ERR %s expected %h actual %h", test_name, expected, actual);
        $display("TEST RESULT: FAIL");
        $fatal(1, "control word mismatch");
    endtask

    a_reset_zero: assert property (@(negedge clk) rst |-> ctrl == '0)
        else report_mismatch('0, ctrl);
    a_word_match: assert property (@(negedge clk) !rst |-> ctrl == exp_word)
        else report_mismatch(exp_word, ctrl);

    task automatic apply(input logic [7:0] b, input logic [3:0] fl, input logic irq);
        @(posedge clk);
        instruction <= isa_pkg::instr_u'(b);
        flags       <= ctrl_pkg::flags_t'(fl);
        interrupt   <= irq;
        test_name   <= phase;                // Name follows its stimulus
    endtask

    initial begin
        #(TEST_CYCLES * PERIOD_NS + 20 * PERIOD_NS);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Watchdog expired before the tests finished");
    end

    initial begin
        logic [7:0] r;
        logic [7:0] q;
        logic [3:0] op;
        instruction = '0;
        flags       = '0;
        interrupt   = 1'b0;
        seed        = 32'd43206;
        test_name   = "reset";
        phase       = "reset";
        @(negedge clk);
        while (rst) @(negedge clk);          // First IDLE cycle sees NOP
        phase = "alu_unary";
        repeat (N_ALU) begin
            r  = rand8();
            q  = rand8();
            op = (r[7:5] > 3'd4) ? 4'd8 : 4'd1 + {1'b0, r[7:5]};
            apply({op, q[3:0]}, r[3:0], 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            r = rand8();
            apply({4'd6, i[1:0], r[1:0]}, 4'h0, 1'b0);
            apply({4'd7, i[1:0], r[3:2]}, 4'h0, 1'b0);
        end
        phase = "cond_branch";
        repeat (N_BRANCH) begin
            r = rand8();
            apply({4'd9, r[7:4]}, r[3:0], 1'b0);
        end
        phase = "two_byte";
        for (int i = 0; i < N_TWO_BYTE; i++) begin
            r = rand8();
            apply({4'hC, i[1:0], r[1:0]}, r[7:4], 1'b0);
            apply(rand8(), 4'h0, 1'b0);      // Immediate byte
            apply({4'd2, r[5:2]}, 4'h0, 1'b0);
        end
        phase = "loop";
        repeat (N_LOOP) begin
            r = rand8();
            apply({4'hA, r[3:0]}, 4'h0, 1'b0);
            apply(8'h00, r[7:4], 1'b0);      // z decides the branch
            apply(8'h00, 4'h0, 1'b0);
        end
        phase = "misc_decode";
        repeat (N_MISC) begin
            r = rand8();
            apply({4'hD, r[3:0]}, r[7:4], 1'b0);        // LDI
            apply({4'hE, r[7:4]}, r[3:0], 1'b0);        // STI
            apply({4'hF, r[5:2]}, 4'h0, 1'b0);          // Spare opcode
            apply({4'hC, 2'd3, r[1:0]}, 4'h0, 1'b0);    // Spare load/store func
            apply({4'hB, 2'd0, r[1:0]}, 4'h0, 1'b0);    // JMP
            apply({4'hB, 2'd1, r[3:2]}, 4'h0, 1'b0);    // CALL
        end
        phase = "interrupt";
        apply(8'h00, 4'h0, 1'b1);
        apply(8'h00, 4'h0, 1'b0);
        apply(8'h00, 4'h0, 1'b0);
        apply(8'hC1, 4'h0, 1'b0);
        apply(8'h5A, 4'h0, 1'b1);            // Raised during FETCH2
        apply(8'h00, 4'h0, 1'b0);
        apply(8'h00, 4'h0, 1'b0);
        apply(8'hA2, 4'h0, 1'b0);
        apply(8'h00, 4'h8, 1'b1);            // Raised during LOOP_DECIDE
        apply(8'h00, 4'h0, 1'b0);
        apply(8'h00, 4'h0, 1'b0);
        apply(8'hB9, 4'h0, 1'b0);            // RET
        apply(8'hBE, 4'h0, 1'b0);            // RTI
        apply(8'h00, 4'h0, 1'b0);
        @(negedge clk);
        @(negedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+source
source/isa_pkg.sv
source/ctrl_pkg.sv
source/instr_decoder.sv
source/ctrl_sequencer.sv
source/control_unit.sv
tests/tb_clock_gen.sv
tests/tb_control_unit.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f verilog.f --top-module tb_control_unit \
		--Mdir obj_dir -o tb_control_unit
	./obj_dir/tb_control_unit

clean:
	rm -rf obj_dir
